// ==== list.f ====
design/pe_set_pkg.sv
design/row_bus_if.sv
design/id_config_seq.sv
design/row_multicast.sv
design/pe_mac.sv
design/psum_collect.sv
design/pe_set.sv
sim/pe_set_tb.sv

// ==== Makefile ====
# Verilator build and run for the pe set testbench

VERILATOR ?= verilator
TOP       ?= pe_set_tb
RTL_TOP   ?= pe_set
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only design/pe_set_pkg.sv design/row_bus_if.sv \
		design/id_config_seq.sv design/row_multicast.sv design/pe_mac.sv \
		design/psum_collect.sv design/pe_set.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/pe_set_tb.sv ====
// pe set testbench
// table-driven config walk, multicast, accumulate and read checks with a reference model
`timescale 1ns/1ps
`default_nettype none

module pe_set_tb
   import pe_set_pkg::*;
();

   typedef enum {op_config, op_weight, op_feature, op_clear, op_read, op_burst} op_t;

   // expected-sum column value that defers to the reference model
   localparam psum_t use_model = '1;
   // ids loaded by the walk in row-major element order and then by row
   localparam id_t cfg_ids [walk_len] = '{8'h20, 8'h21, 8'h30, 8'h30, 8'h10, 8'h11};

   logic                     clk;
   logic                     rst_n;
   logic                     start_config;
   id_t                      cfg_weight_id;
   id_t                      cfg_feature_id;
   logic                     bus_weight_valid;
   id_t                      bus_weight_row_id;
   id_t                      bus_weight_col_id;
   data_t                    bus_weight_in;
   logic                     bus_feature_valid;
   id_t                      bus_feature_row_id;
   id_t                      bus_feature_col_id;
   data_t                    bus_feature_in;
   logic                     psum_clear;
   logic                     psum_read;
   logic [row_sel_width-1:0] psum_read_row;
   logic [col_sel_width-1:0] psum_read_col;
   logic [cnt_width-1:0]     config_cnt;
   logic                     config_finish;
   logic                     bus_psum_out_valid;
   psum_t                    bus_psum_out;

   // stimulus table with one entry per index
   string t_name [$];
   op_t   t_op   [$];
   id_t   t_row  [$];
   id_t   t_col  [$];
   data_t t_data [$];
   bit    t_rnd  [$];
   psum_t t_exp  [$];
   logic  table_loaded = 1'b0;

   // reference model
   id_t   m_row_wid [pe_row_num];
   id_t   m_row_fid [pe_row_num];
   id_t   m_col_wid [pe_num];
   id_t   m_col_fid [pe_num];
   data_t m_weight  [pe_num];
   psum_t m_sum     [pe_num];

   int    pos_q [$];
   psum_t exp_q [$];
   int    errors   = 0;
   int    pass_cnt = 0;
   int    fail_cnt = 0;

   pe_set pe_set_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------
   // table and model helpers
   // ------------------------------
   task automatic add_test(input string name, input op_t op, input id_t row, input id_t col,
                           input data_t data, input bit rnd, input psum_t exp);
      t_name.push_back(name);
      t_op.push_back(op);
      t_row.push_back(row);
      t_col.push_back(col);
      t_data.push_back(data);
      t_rnd.push_back(rnd);
      t_exp.push_back(exp);
   endtask

   task automatic load_table();
      add_test("config_walk",    op_config,  8'h00, 8'h00, 16'd0, 1'b0, 0);
      add_test("uc_weight",      op_weight,  8'h10, 8'h20, 16'd3, 1'b0, 0);
      add_test("uc_feat_a",      op_feature, 8'h90, 8'ha0, 16'd5, 1'b0, 0);
      add_test("uc_feat_b",      op_feature, 8'h90, 8'ha0, 16'd7, 1'b0, 0);
      add_test("uc_read_p0",     op_read,    8'd0,  8'd0,  16'd0, 1'b0, 40'd36);
      add_test("uc_feat_rnd",    op_feature, 8'h90, 8'ha0, 16'd0, 1'b1, 0);
      add_test("uc_read_rnd",    op_read,    8'd0,  8'd0,  16'd0, 1'b0, use_model);
      add_test("uc_read_p1",     op_read,    8'd0,  8'd1,  16'd0, 1'b0, 40'd0);
      add_test("uc_read_p2",     op_read,    8'd1,  8'd0,  16'd0, 1'b0, 40'd0);
      add_test("mc_weight",      op_weight,  8'h11, 8'h30, 16'd4, 1'b0, 0);
      add_test("mc_feat",        op_feature, 8'h91, 8'hb0, 16'd6, 1'b0, 0);
      add_test("mc_weight_miss", op_weight,  8'h55, 8'h30, 16'd9, 1'b0, 0);
      add_test("mc_feat_miss",   op_feature, 8'h55, 8'hb0, 16'd9, 1'b0, 0);
      add_test("mc_read_p2",     op_read,    8'd1,  8'd0,  16'd0, 1'b0, 40'd24);
      add_test("mc_read_p3",     op_read,    8'd1,  8'd1,  16'd0, 1'b0, 40'd24);
      add_test("burst_read",     op_burst,   8'd0,  8'd0,  16'd0, 1'b0, use_model);
      add_test("clear",          op_clear,   8'd0,  8'd0,  16'd0, 1'b0, 0);
      add_test("clear_read_p0",  op_read,    8'd0,  8'd0,  16'd0, 1'b0, 40'd0);
      add_test("clear_read_p3",  op_read,    8'd1,  8'd1,  16'd0, 1'b0, 40'd0);
      add_test("reacc_feat",     op_feature, 8'h91, 8'hb0, 16'd2, 1'b0, 0);
      add_test("reacc_read_p2",  op_read,    8'd1,  8'd0,  16'd0, 1'b0, 40'd8);
      add_test("reacc_feat_rnd", op_feature, 8'h90, 8'ha0, 16'd0, 1'b1, 0);
      add_test("final_burst",    op_burst,   8'd0,  8'd0,  16'd0, 1'b0, use_model);
   endtask

   // apply one bus item to the model by row and column tags
   task automatic model_item(input bit is_weight, input id_t row, input id_t col, input data_t d);
      int p;
      for (int r = 0; r < pe_row_num; r++) begin
         for (int c = 0; c < pe_col_num; c++) begin
            p = r * pe_col_num + c;
            if (is_weight && m_row_wid[r] == row && m_col_wid[p] == col)
               m_weight[p] = d;
            if (!is_weight && m_row_fid[r] == row && m_col_fid[p] == col)
               m_sum[p] = m_sum[p] + psum_t'(m_weight[p]) * psum_t'(d);
         end
      end
   endtask

   // ------------------------------
   // operations
   // ------------------------------
   task automatic configure_ids(input string name);
      int   exp_cnt;
      logic exp_fin;
      for (int n = 0; n <= walk_len + 2; n++) begin
         @(posedge clk);
         // raise at n 0, second start during the walk at n 2
         start_config <= (n == 0 || n == 2);
         if (n >= 1 && n <= walk_len) begin
            cfg_weight_id  <= cfg_ids[n-1];
            cfg_feature_id <= cfg_ids[n-1] ^ 8'h80;
         end
         @(negedge clk);
         exp_cnt = (n >= 1 && n <= walk_len) ? n : 0;
         exp_fin = (n == walk_len + 1);
         if (config_cnt !== cnt_width'(exp_cnt)) begin
            $display("error %s: expected %0d actual %0d", name, exp_cnt, config_cnt);
            errors++;
         end
         if (config_finish !== exp_fin) begin
            $display("error %s: expected %0b actual %0b", name, exp_fin, config_finish);
            errors++;
         end
      end
      for (int p = 0; p < pe_num; p++) begin
         m_col_wid[p] = cfg_ids[p];
         m_col_fid[p] = cfg_ids[p] ^ 8'h80;
      end
      for (int r = 0; r < pe_row_num; r++) begin
         m_row_wid[r] = cfg_ids[pe_num+r];
         m_row_fid[r] = cfg_ids[pe_num+r] ^ 8'h80;
      end
   endtask

   task automatic send_item(input bit is_weight, input id_t row, input id_t col, input data_t d);
      @(posedge clk);
      if (is_weight) begin
         bus_weight_valid  <= 1'b1;
         bus_weight_row_id <= row;
         bus_weight_col_id <= col;
         bus_weight_in     <= d;
      end else begin
         bus_feature_valid  <= 1'b1;
         bus_feature_row_id <= row;
         bus_feature_col_id <= col;
         bus_feature_in     <= d;
      end
      @(posedge clk);
      bus_weight_valid  <= 1'b0;
      bus_feature_valid <= 1'b0;
      // let the item pass row controller and element
      repeat (3) @(posedge clk);
   endtask

   task automatic clear_sums();
      @(posedge clk);
      psum_clear <= 1'b1;
      @(posedge clk);
      psum_clear <= 1'b0;
      for (int p = 0; p < pe_num; p++)
         m_sum[p] = '0;
   endtask

   // back-to-back reads of pos_q with each result due 2 cycles after its strobe
   task automatic issue_reads(input string name);
      int n;
      n = pos_q.size();
      for (int e = 0; e <= n + 2; e++) begin
         @(posedge clk);
         if (e < n) begin
            psum_read     <= 1'b1;
            psum_read_row <= row_sel_width'(pos_q[e] / pe_col_num);
            psum_read_col <= col_sel_width'(pos_q[e] % pe_col_num);
         end else begin
            psum_read <= 1'b0;
         end
         @(negedge clk);
         if (e >= 2 && e - 2 < n) begin
            if (bus_psum_out_valid !== 1'b1) begin
               $display("%s: no output valid for read %0d", name, e - 2);
               errors++;
            end else if (bus_psum_out !== exp_q[e-2]) begin
               $display("error %s: expected %h actual %h", name, exp_q[e-2], bus_psum_out);
               errors++;
            end
         end else if (bus_psum_out_valid !== 1'b0) begin
            $display("%s: output valid without a pending read at step %0d", name, e);
            errors++;
         end
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      int    errs_before;
      int    pos;
      data_t d;
      void'($urandom(32'h55e873b5));
      rst_n              = 1'b0;
      start_config       = 1'b0;
      cfg_weight_id      = '0;
      cfg_feature_id     = '0;
      bus_weight_valid   = 1'b0;
      bus_weight_row_id  = '0;
      bus_weight_col_id  = '0;
      bus_weight_in      = '0;
      bus_feature_valid  = 1'b0;
      bus_feature_row_id = '0;
      bus_feature_col_id = '0;
      bus_feature_in     = '0;
      psum_clear         = 1'b0;
      psum_read          = 1'b0;
      psum_read_row      = '0;
      psum_read_col      = '0;
      for (int p = 0; p < pe_num; p++) begin
         m_col_wid[p] = '0;
         m_col_fid[p] = '0;
         m_weight[p]  = '0;
         m_sum[p]     = '0;
      end
      for (int r = 0; r < pe_row_num; r++) begin
         m_row_wid[r] = '0;
         m_row_fid[r] = '0;
      end
      load_table();
      table_loaded = 1'b1;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < t_name.size(); i++) begin
         errs_before = errors;
         pos_q = {};
         exp_q = {};
         case (t_op[i])
            op_config: configure_ids(t_name[i]);
            op_weight, op_feature: begin
               d = t_rnd[i] ? data_t'($urandom) : t_data[i];
               send_item(t_op[i] == op_weight, t_row[i], t_col[i], d);
               model_item(t_op[i] == op_weight, t_row[i], t_col[i], d);
            end
            op_clear: clear_sums();
            op_read: begin
               pos = int'(t_row[i]) * pe_col_num + int'(t_col[i]);
               pos_q.push_back(pos);
               exp_q.push_back((t_exp[i] == use_model) ? m_sum[pos] : t_exp[i]);
               issue_reads(t_name[i]);
            end
            default: begin
               for (int p = 0; p < pe_num; p++) begin
                  pos_q.push_back(p);
                  exp_q.push_back(m_sum[p]);
               end
               issue_reads(t_name[i]);
            end
         endcase
         if (errors == errs_before) begin
            pass_cnt++;
            $display("test %-16s ok", t_name[i]);
         end else begin
            fail_cnt++;
            $display("test %-16s failed", t_name[i]);
         end
      end
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // watchdog of about 20 cycles per table entry plus a margin
   initial begin
      wait (table_loaded);
      repeat (t_name.size() * 20 + 100) @(posedge clk);
      $display("watchdog timeout, the test table did not finish");
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/pe_set.sv ====
// row-stationary pe set
// config sequencer, one multicast controller per row, element grid, psum collector
`timescale 1ns/1ps
`default_nettype none

module pe_set
   import pe_set_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start_config,
   input  id_t                      cfg_weight_id,
   input  id_t                      cfg_feature_id,
   // weight bus
   input  logic                     bus_weight_valid,
   input  id_t                      bus_weight_row_id,
   input  id_t                      bus_weight_col_id,
   input  data_t                    bus_weight_in,
   // feature bus
   input  logic                     bus_feature_valid,
   input  id_t                      bus_feature_row_id,
   input  id_t                      bus_feature_col_id,
   input  data_t                    bus_feature_in,
   // read side
   input  logic                     psum_clear,
   input  logic                     psum_read,
   input  logic [row_sel_width-1:0] psum_read_row,
   input  logic [col_sel_width-1:0] psum_read_col,
   output logic [cnt_width-1:0]     config_cnt,
   output logic                     config_finish,
   output logic                     bus_psum_out_valid,
   output psum_t                    bus_psum_out
);

   logic [pe_num-1:0]     pe_ce;
   logic [pe_row_num-1:0] row_ce;
   logic [pe_num-1:0]     pe_sel;
   logic [pe_num-1:0]     pe_valid;
   psum_t                 pe_psum [pe_num];

   id_config_seq cfg_seq_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .start_config  (start_config),
      .config_cnt    (config_cnt),
      .config_finish (config_finish),
      .pe_ce         (pe_ce),
      .row_ce        (row_ce)
   );

   // ------------------------------
   // element grid
   // ------------------------------
   for (genvar r = 0; r < pe_row_num; r++) begin : g_row
      row_bus_if rb ();

      row_multicast row_mc_i (
         .clk                (clk),
         .rst_n              (rst_n),
         .row_ce             (row_ce[r]),
         .cfg_weight_id      (cfg_weight_id),
         .cfg_feature_id     (cfg_feature_id),
         .bus_weight_valid   (bus_weight_valid),
         .bus_weight_row_id  (bus_weight_row_id),
         .bus_weight_col_id  (bus_weight_col_id),
         .bus_weight_in      (bus_weight_in),
         .bus_feature_valid  (bus_feature_valid),
         .bus_feature_row_id (bus_feature_row_id),
         .bus_feature_col_id (bus_feature_col_id),
         .bus_feature_in     (bus_feature_in),
         .rb                 (rb)
      );

      for (genvar c = 0; c < pe_col_num; c++) begin : g_col
         // row-major read select
         assign pe_sel[r*pe_col_num+c] = psum_read
                                       && (psum_read_row == row_sel_width'(r))
                                       && (psum_read_col == col_sel_width'(c));

         pe_mac pe_i (
            .clk            (clk),
            .rst_n          (rst_n),
            .pe_ce          (pe_ce[r*pe_col_num+c]),
            .cfg_weight_id  (cfg_weight_id),
            .cfg_feature_id (cfg_feature_id),
            .rb             (rb),
            .psum_clear     (psum_clear),
            .sel            (pe_sel[r*pe_col_num+c]),
            .psum_valid     (pe_valid[r*pe_col_num+c]),
            .psum           (pe_psum[r*pe_col_num+c])
         );
      end
   end

   // ------------------------------
   // result
   // ------------------------------
   psum_collect collect_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .pe_valid           (pe_valid),
      .pe_psum            (pe_psum),
      .bus_psum_out_valid (bus_psum_out_valid),
      .bus_psum_out       (bus_psum_out)
   );

endmodule

`default_nettype wire

// ==== design/psum_collect.sv ====
// partial-sum collector
// OR-combines the element read ports and registers the output bus
`timescale 1ns/1ps
`default_nettype none

module psum_collect
   import pe_set_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [pe_num-1:0] pe_valid,
   input  psum_t             pe_psum [pe_num],
   output logic              bus_psum_out_valid,
   output psum_t             bus_psum_out
);

   logic  any_valid;
   psum_t any_psum;

   // ------------------------------
   // OR chain over all elements
   // ------------------------------
   // only the selected element is non-zero
   always_comb begin
      any_valid = 1'b0;
      any_psum  = '0;
      for (int i = 0; i < pe_num; i++) begin
         any_valid = any_valid | pe_valid[i];
         any_psum  = any_psum | pe_psum[i];
      end
   end

   // output register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus_psum_out_valid <= 1'b0;
         bus_psum_out       <= '0;
      end else begin
         bus_psum_out_valid <= any_valid;
         bus_psum_out       <= any_psum;
      end
   end

endmodule

`default_nettype wire

// ==== design/pe_mac.sv ====
// processing element
// column tag match, one stationary weight and a multiply-accumulate sum
`timescale 1ns/1ps
`default_nettype none

module pe_mac
   import pe_set_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    pe_ce,
   input  id_t     cfg_weight_id,
   input  id_t     cfg_feature_id,
   row_bus_if.pe   rb,
   input  logic    psum_clear,
   input  logic    sel,
   output logic    psum_valid,
   output psum_t   psum
);

   id_t                       col_weight_id;
   id_t                       col_feature_id;
   data_t                     weight;
   psum_t                     acc;
   logic                      weight_hit;
   logic                      feature_hit;
   logic [2*data_width-1:0]   product;

   // column ids from the configuration walk
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col_weight_id  <= '0;
         col_feature_id <= '0;
      end else if (pe_ce) begin
         col_weight_id  <= cfg_weight_id;
         col_feature_id <= cfg_feature_id;
      end
   end

   assign weight_hit  = rb.weight_valid && (rb.weight_col_id == col_weight_id);
   assign feature_hit = rb.feature_valid && (rb.feature_col_id == col_feature_id);

   // ------------------------------
   // execute
   // ------------------------------
   // a feature in the same cycle as a new weight still sees the old one
   assign product = weight * rb.feature_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         weight <= '0;
      end else if (weight_hit) begin
         weight <= rb.weight_data;
      end
   end

   // clear wins over a feature arriving at the same edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (psum_clear) begin
         acc <= '0;
      end else if (feature_hit) begin
         acc <= acc + psum_t'(product);
      end
   end

   // ------------------------------
   // read port
   // ------------------------------
   // unselected elements drive zeros so the collector can OR them
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         psum_valid <= 1'b0;
         psum       <= '0;
      end else begin
         psum_valid <= sel;
         psum       <= sel ? acc : '0;
      end
   end

endmodule

`default_nettype wire

// ==== design/row_multicast.sv ====
// row multicast controller
// decodes the row tag of each bus item and forwards hits onto the row bus
`timescale 1ns/1ps
`default_nettype none

module row_multicast
   import pe_set_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      row_ce,
   input  id_t       cfg_weight_id,
   input  id_t       cfg_feature_id,
   input  logic      bus_weight_valid,
   input  id_t       bus_weight_row_id,
   input  id_t       bus_weight_col_id,
   input  data_t     bus_weight_in,
   input  logic      bus_feature_valid,
   input  id_t       bus_feature_row_id,
   input  id_t       bus_feature_col_id,
   input  data_t     bus_feature_in,
   row_bus_if.ctrl   rb
);

   id_t  row_weight_id;
   id_t  row_feature_id;
   logic weight_hit;
   logic feature_hit;

   // row ids, loaded during the configuration walk
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_weight_id  <= '0;
         row_feature_id <= '0;
      end else if (row_ce) begin
         row_weight_id  <= cfg_weight_id;
         row_feature_id <= cfg_feature_id;
      end
   end

   // ------------------------------
   // decode
   // ------------------------------
   assign weight_hit  = bus_weight_valid && (bus_weight_row_id == row_weight_id);
   assign feature_hit = bus_feature_valid && (bus_feature_row_id == row_feature_id);

   // strobes onto the row bus
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rb.weight_valid  <= 1'b0;
         rb.feature_valid <= 1'b0;
      end else begin
         rb.weight_valid  <= weight_hit;
         rb.feature_valid <= feature_hit;
      end
   end

   // payload only moves on a hit
   always_ff @(posedge clk) begin
      if (weight_hit) begin
         rb.weight_data   <= bus_weight_in;
         rb.weight_col_id <= bus_weight_col_id;
      end
      if (feature_hit) begin
         rb.feature_data   <= bus_feature_in;
         rb.feature_col_id <= bus_feature_col_id;
      end
   end

endmodule

`default_nettype wire

// ==== design/id_config_seq.sv ====
// configuration sequencer
// walks a one-hot enable over all elements and then all rows, one per cycle
`timescale 1ns/1ps
`default_nettype none

module id_config_seq
   import pe_set_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start_config,
   output logic [cnt_width-1:0]  config_cnt,
   output logic                  config_finish,
   output logic [pe_num-1:0]     pe_ce,
   output logic [pe_row_num-1:0] row_ce
);

   cfg_state_t          state;
   logic [walk_len-1:0] walk;

   // ------------------------------
   // walk FSM
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= cfg_idle;
         walk          <= '0;
         config_cnt    <= '0;
         config_finish <= 1'b0;
      end else begin
         // finish is a single pulse
         config_finish <= 1'b0;
         case (state)
            cfg_idle: begin
               if (start_config) begin
                  state      <= cfg_walk;
                  walk       <= {{(walk_len-1){1'b0}}, 1'b1};
                  config_cnt <= cnt_width'(1);
               end
            end
            cfg_walk: begin
               // start_config is not looked at here
               if (config_cnt == cnt_width'(walk_len)) begin
                  state         <= cfg_idle;
                  walk          <= '0;
                  config_cnt    <= '0;
                  config_finish <= 1'b1;
               end else begin
                  walk       <= walk << 1;
                  config_cnt <= config_cnt + 1'b1;
               end
            end
            default: begin
               state <= cfg_idle;
            end
         endcase
      end
   end

   // lower bits reach the elements in row-major order, upper bits the rows
   assign pe_ce  = walk[pe_num-1:0];
   assign row_ce = walk[walk_len-1:pe_num];

endmodule

`default_nettype wire

// ==== design/row_bus_if.sv ====
// row bus between one row controller and the elements of its row
// single-cycle weight and feature strobes with their column tags
`timescale 1ns/1ps
`default_nettype none

interface row_bus_if
   import pe_set_pkg::*;
();

   // weight lane
   logic  weight_valid;
   data_t weight_data;
   id_t   weight_col_id;

   // feature lane
   logic  feature_valid;
   data_t feature_data;
   id_t   feature_col_id;

   modport ctrl (
      output weight_valid, weight_data, weight_col_id,
      output feature_valid, feature_data, feature_col_id
   );

   modport pe (
      input weight_valid, weight_data, weight_col_id,
      input feature_valid, feature_data, feature_col_id
   );

endinterface

`default_nettype wire

// ==== design/pe_set_pkg.sv ====
// pe set shared definitions
// array sizes, bus widths and the configuration walk state
`default_nettype none

package pe_set_pkg;

   // ------------------------------
   // array geometry
   // ------------------------------
   localparam int pe_row_num = 2;
   localparam int pe_col_num = 2;
   localparam int pe_num     = pe_row_num * pe_col_num;

   // enable walk covers every element first, then every row controller
   localparam int walk_len = pe_num + pe_row_num;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int data_width = 16;
   localparam int psum_width = 40;
   localparam int id_width   = 8;

   // must hold pe_num + pe_row_num + 1
   localparam int cnt_width = 4;

   // read position select widths
   localparam int row_sel_width = $clog2(pe_row_num);
   localparam int col_sel_width = $clog2(pe_col_num);

   // ------------------------------
   // types
   // ------------------------------
   typedef logic [data_width-1:0] data_t;
   typedef logic [psum_width-1:0] psum_t;
   typedef logic [id_width-1:0]   id_t;

   // configuration sequencer
   typedef enum logic {
      cfg_idle,
      cfg_walk
   } cfg_state_t;

endpackage

`default_nettype wire
